/* testbench/audio_patterns.hex */
// kind_addr_data_cpcl_cpcr_move_flags_expl_expr; kind 1 write 2 inputs 3 steady 4 range 5 status
// flags: 0 collision 1 mode 2 random cpc 3 both levels; exp FF means pass-through
2_00_00_00_00_00_2_00_00
3_00_04_00_00_00_0_FF_FF
5_00_00_00_00_00_0_00_00
1_40_80_00_00_00_0_00_00
1_41_80_00_00_00_0_00_00
2_00_00_00_00_00_6_00_00
3_00_08_00_00_00_0_FF_FF
2_00_00_00_00_00_4_00_00
1_40_20_00_00_00_0_00_00
1_41_20_00_00_00_0_00_00
3_00_08_00_00_00_0_FF_FF
2_00_00_00_00_00_6_00_00
1_40_FF_00_00_00_0_00_00
3_00_04_00_00_00_0_FF_FF
1_42_80_00_00_00_0_00_00
4_01_2C_00_00_00_8_FE_00
1_42_00_00_00_00_0_00_00
1_46_FF_00_00_00_0_00_00
1_47_FF_00_00_00_0_00_00
1_49_00_00_00_00_0_00_00
1_4A_01_00_00_00_0_00_00
4_01_2C_00_00_00_0_FD_00
5_00_00_00_00_00_0_01_00
1_4A_00_00_00_00_0_00_00
2_00_00_00_00_00_7_00_00
3_00_04_00_00_00_0_F0_FF
5_00_00_00_00_00_0_80_00
2_00_00_00_00_5A_6_00_00
3_00_04_00_00_00_0_FF_F0
5_00_00_00_00_00_0_80_00
2_00_00_00_00_00_6_00_00
3_00_04_00_00_00_0_FF_FF
5_00_00_00_00_00_0_00_00
0_00_00_00_00_00_0_00_00

/* verilog.f */
design/audio_mix_pkg.sv
design/audio_reg_pkg.sv
design/audio_regs.sv
design/tone_gen.sv
design/sfx_voices.sv
design/audio_mixer.sv
design/gx4000_audio.sv
testbench/tb_gx4000_audio.sv

/* Bender.yml */
package:
  name: gx4000_audio

sources:
  - design/audio_mix_pkg.sv
  - design/audio_reg_pkg.sv
  - design/audio_regs.sv
  - design/tone_gen.sv
  - design/sfx_voices.sv
  - design/audio_mixer.sv
  - design/gx4000_audio.sv
  - target: test
    files:
      - testbench/tb_gx4000_audio.sv

/* testbench/tb_gx4000_audio.sv */
`timescale 1ns/1ps

module tb_gx4000_audio import audio_mix_pkg::*, audio_reg_pkg::*; ();

    localparam int clk_half = 20;
    localparam int drive_delay = 2;
    localparam int wait_limit = 600;
    localparam int max_rows = 64;

    // One row of the pattern file
    typedef struct packed {
        logic [3:0] kind;
        reg_addr_t  addr;
        sample_t    data;
        sample_t    cpc_l;
        sample_t    cpc_r;
        sample_t    movement;
        logic [3:0] flags;
        sample_t    exp_l;
        sample_t    exp_r;
    } pattern_t;

    logic        clk_sys;
    logic        reset;
    logic        gx4000_mode;
    logic        sprite_collision;
    logic        cpu_wr;
    logic [15:0] cpu_addr;
    sample_t     cpu_data;
    sample_t     cpc_audio_l;
    sample_t     cpc_audio_r;
    sample_t     sprite_movement;
    sample_t     audio_l;
    sample_t     audio_r;
    logic [7:0]  audio_status;

    logic [63:0] raw_rows [max_rows];
    integer      seed;
    int          value_errors;
    int          other_errors;
    sample_t     vol_l;
    sample_t     vol_r;

    gx4000_audio UUT (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .gx4000_mode      (gx4000_mode),
        .sprite_collision (sprite_collision),
        .cpu_wr           (cpu_wr),
        .cpu_addr         (cpu_addr),
        .cpu_data         (cpu_data),
        .cpc_audio_l      (cpc_audio_l),
        .cpc_audio_r      (cpc_audio_r),
        .sprite_movement  (sprite_movement),
        .audio_l          (audio_l),
        .audio_r          (audio_r),
        .audio_status     (audio_status)
    );

    always #(clk_half) clk_sys = ~clk_sys;

    task automatic next_cycle();
        @(posedge clk_sys);
        #(drive_delay);
    endtask

    // Limiter at the 0xF0 ceiling
    function automatic sample_t limited(logic [8:0] sum);
        return (sum > 9'h0F0) ? 8'hF0 : sum[7:0];
    endfunction

    function automatic sample_t pass_level(sample_t cpc, sample_t volume);
        logic [15:0] prod;
        prod = cpc * volume;
        return limited({1'b0, prod[15:8]});
    endfunction

    // 0xFF in the file stands for the pass-through level
    function automatic sample_t steady_value(sample_t field, sample_t cpc, sample_t volume);
        return (field == 8'hFF) ? pass_level(cpc, volume) : field;
    endfunction

    task automatic check_sample(string name, sample_t got, sample_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
            value_errors++;
        end
    endtask

    task automatic check_status(logic [7:0] got, logic [7:0] expected);
        if (got !== expected) begin
            $display("[FAIL] audio_status got 0x%h expected 0x%h at %0t", got, expected, $time);
            value_errors++;
        end
    endtask

    task automatic cpu_write(reg_addr_t addr, sample_t data);
        cpu_addr = {8'h00, addr};
        cpu_data = data;
        cpu_wr = 1'b1;
        if (gx4000_mode && addr == addr_volume_l) begin
            vol_l = data;
        end
        if (gx4000_mode && addr == addr_volume_r) begin
            vol_r = data;
        end
        next_cycle();
        cpu_wr = 1'b0;
    endtask

    task automatic set_inputs(pattern_t row);
        gx4000_mode = row.flags[1];
        sprite_collision = row.flags[0];
        sprite_movement = row.movement;
        if (row.flags[2]) begin
            // Kept below 0x80 so full volume never reaches the ceiling
            cpc_audio_l = sample_t'($random(seed)) & 8'h7F;
            cpc_audio_r = sample_t'($random(seed)) & 8'h7F;
        end else begin
            cpc_audio_l = row.cpc_l;
            cpc_audio_r = row.cpc_r;
        end
    endtask

    task automatic expect_steady(pattern_t row);
        sample_t exp_l;
        sample_t exp_r;
        int      waited;
        exp_l = steady_value(row.exp_l, cpc_audio_l, vol_l);
        exp_r = steady_value(row.exp_r, cpc_audio_r, vol_r);
        waited = 0;
        while ((audio_l !== exp_l || audio_r !== exp_r) && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (audio_l !== exp_l || audio_r !== exp_r) begin
            $display("Timeout: outputs did not settle within %0d cycles", wait_limit);
            other_errors++;
        end
        for (int i = 0; i < row.data; i++) begin
            check_sample("audio_l", audio_l, exp_l);
            check_sample("audio_r", audio_r, exp_r);
            next_cycle();
        end
    endtask

    task automatic expect_status(pattern_t row);
        int waited;
        waited = 0;
        while (audio_status !== row.exp_l && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (audio_status !== row.exp_l) begin
            $display("Timeout: status did not settle within %0d cycles", wait_limit);
            other_errors++;
        end
        check_status(audio_status, row.exp_l);
    endtask

    // Each sample is either the base level or base plus delta
    task automatic range_sample(string name, sample_t got, sample_t base, sample_t delta,
                                inout int hits_base, inout int hits_high);
        if (delta != 8'h00 && got === limited({1'b0, base} + {1'b0, delta})) begin
            hits_high++;
        end else if (got === base) begin
            hits_base++;
        end else begin
            check_sample(name, got, base);
        end
    endtask

    task automatic expect_range(pattern_t row);
        int base_l;
        int high_l;
        int base_r;
        int high_r;
        base_l = 0;
        high_l = 0;
        base_r = 0;
        high_r = 0;
        for (int i = 0; i < {row.addr, row.data}; i++) begin
            next_cycle();
            range_sample("audio_l", audio_l, pass_level(cpc_audio_l, vol_l), row.exp_l,
                         base_l, high_l);
            range_sample("audio_r", audio_r, pass_level(cpc_audio_r, vol_r), row.exp_r,
                         base_r, high_r);
        end
        if ((row.exp_l != 8'h00 && high_l == 0) || (row.exp_r != 8'h00 && high_r == 0)) begin
            $display("Raised level never appeared on a modulated channel");
            other_errors++;
        end
        if (row.flags[3] && (base_l == 0 || base_r == 0)) begin
            $display("Pass-through level never appeared during the range check");
            other_errors++;
        end
    endtask

    initial begin
        pattern_t row;
        clk_sys = 1'b0;
        reset = 1'b1;
        gx4000_mode = 1'b0;
        // Both clicks held through reset, so uncleared outputs would clip
        sprite_collision = 1'b1;
        cpu_wr = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        cpc_audio_l = '0;
        cpc_audio_r = '0;
        sprite_movement = 8'hFF;
        seed = 32'hb5cd_9514;
        value_errors = 0;
        other_errors = 0;
        vol_l = '0;
        vol_r = '0;
        for (int i = 0; i < max_rows; i++) begin
            raw_rows[i] = '0;
        end
        $readmemh("testbench/audio_patterns.hex", raw_rows);
        if (raw_rows[0][63:60] == 4'h0) begin
            $display("Pattern file holds no rows");
            other_errors++;
        end
        repeat (4) @(posedge clk_sys);
        #(drive_delay);
        check_sample("audio_l", audio_l, 8'h00);
        check_sample("audio_r", audio_r, 8'h00);
        check_status(audio_status, 8'h00);
        reset = 1'b0;
        sprite_collision = 1'b0;
        sprite_movement = '0;
        for (int i = 0; i < max_rows; i++) begin
            row = pattern_t'(raw_rows[i]);
            if (row.kind == 4'h0) begin
                break;
            end
            case (row.kind)
                4'h1: cpu_write(row.addr, row.data);
                4'h2: set_inputs(row);
                4'h3: expect_steady(row);
                4'h4: expect_range(row);
                4'h5: expect_status(row);
                default: begin
                    $display("Unknown row kind %0h in row %0d", row.kind, i);
                    other_errors++;
                end
            endcase
        end
        $display("Run done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* design/gx4000_audio.sv */
`timescale 1ns/1ps

module gx4000_audio import audio_mix_pkg::*, audio_reg_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        gx4000_mode,
    input  logic        sprite_collision,
    input  logic        cpu_wr,
    input  logic [15:0] cpu_addr,
    input  sample_t     cpu_data,
    input  sample_t     cpc_audio_l,
    input  sample_t     cpc_audio_r,
    input  sample_t     sprite_movement,
    output sample_t     audio_l,
    output sample_t     audio_r,
    output logic [7:0]  audio_status
);

    audio_ctrl_t ctrl;
    stereo_t     cpc_audio;
    stereo_t     tone_level;
    stereo_t     sfx_level;

    assign cpc_audio = '{l: cpc_audio_l, r: cpc_audio_r};

    // Only the low address byte selects a register
    audio_regs u_regs (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cpu_wr      (cpu_wr),
        .cpu_addr    (cpu_addr[7:0]),
        .cpu_data    (cpu_data),
        .ctrl        (ctrl)
    );

    tone_gen u_tone (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .ctrl        (ctrl),
        .tone_level  (tone_level)
    );

    sfx_voices u_sfx (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .ctrl        (ctrl),
        .sfx_level   (sfx_level)
    );

    audio_mixer u_mixer (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .ctrl             (ctrl),
        .cpc_audio        (cpc_audio),
        .tone_level       (tone_level),
        .sfx_level        (sfx_level),
        .sprite_collision (sprite_collision),
        .sprite_movement  (sprite_movement),
        .audio_l          (audio_l),
        .audio_r          (audio_r),
        .audio_status     (audio_status)
    );

endmodule

/* design/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer import audio_mix_pkg::*, audio_reg_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  audio_ctrl_t ctrl,
    input  stereo_t     cpc_audio,
    input  stereo_t     tone_level,
    input  stereo_t     sfx_level,
    input  logic        sprite_collision,
    input  sample_t     sprite_movement,
    output sample_t     audio_l,
    output sample_t     audio_r,
    output logic [7:0]  audio_status
);

    mix_t                  sum_l;
    mix_t                  sum_r;
    logic                  clip_l;
    logic                  clip_r;
    logic [num_voices-1:0] voice_active;

    // One side of the mix before the limiter
    function automatic mix_t side_sum(sample_t cpc, sample_t volume, sample_t tone,
                                      sample_t sfx, logic click);
        logic [15:0] cpc_scaled;
        logic [15:0] tone_scaled;
        mix_t        click_term;
        cpc_scaled = cpc * volume;
        tone_scaled = tone * volume;
        click_term = click ? mix_t'(level_max) : '0;
        return mix_t'(cpc_scaled[15:8]) + mix_t'(tone_scaled[15:8]) + mix_t'(sfx) +
               click_term;
    endfunction

    always_comb begin
        sum_l = side_sum(cpc_audio.l, ctrl.volume_l, tone_level.l, sfx_level.l,
                         sprite_collision);
        sum_r = side_sum(cpc_audio.r, ctrl.volume_r, tone_level.r, sfx_level.r,
                         sprite_movement != '0);
        clip_l = sum_l > mix_t'(limit_ceiling);
        clip_r = sum_r > mix_t'(limit_ceiling);
        for (int v = 0; v < num_voices; v++) begin
            voice_active[v] = ctrl.voice[v].active;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_l <= '0;
            audio_r <= '0;
            audio_status <= '0;
        end else begin
            audio_l <= clip_to(sum_l, limit_ceiling);
            audio_r <= clip_to(sum_r, limit_ceiling);
            // Clip flag on top, voice activity in the low nibble
            audio_status <= {clip_l | clip_r, 3'b000, voice_active};
        end
    end

endmodule

/* design/sfx_voices.sv */
`timescale 1ns/1ps

module sfx_voices import audio_mix_pkg::*, audio_reg_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        gx4000_mode,
    input  audio_ctrl_t ctrl,
    output stereo_t     sfx_level
);

    sample_t                phase [num_voices];
    logic [num_voices-1:0]  voice_wave;
    mix_t                   sum_l;
    mix_t                   sum_r;

    // Full-scale wave times volume times pan factor, top byte kept
    function automatic sample_t pan_scale(sample_t volume, sample_t factor);
        logic [23:0] prod;
        prod = level_max * volume * factor;
        return prod[23:16];
    endfunction

    // Inactive voices hold their phase
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int v = 0; v < num_voices; v++) begin
                phase[v] <= '0;
            end
        end else if (gx4000_mode) begin
            for (int v = 0; v < num_voices; v++) begin
                if (ctrl.voice[v].active) begin
                    phase[v] <= phase[v] + ctrl.voice[v].freq;
                end
            end
        end
    end

    always_comb begin
        for (int v = 0; v < num_voices; v++) begin
            voice_wave[v] = ctrl.voice[v].active && (phase[v] < ctrl.voice[v].freq);
        end
    end

    // Pan 0 is hard left, 0xFF hard right
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < num_voices; v++) begin
            if (voice_wave[v]) begin
                sum_l = sum_l + mix_t'(pan_scale(ctrl.voice[v].volume,
                                                 level_max - ctrl.voice[v].pan));
                sum_r = sum_r + mix_t'(pan_scale(ctrl.voice[v].volume,
                                                 ctrl.voice[v].pan));
            end
        end
        sfx_level.l = clip_to(sum_l, level_max);
        sfx_level.r = clip_to(sum_r, level_max);
    end

endmodule

/* design/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen import audio_mix_pkg::*, audio_reg_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        gx4000_mode,
    input  audio_ctrl_t ctrl,
    output stereo_t     tone_level
);

    // Free-running phase per side
    stereo_t phase;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            phase <= '0;
        end else if (gx4000_mode) begin
            phase.l <= phase.l + 8'd1;
            phase.r <= phase.r + 8'd1;
        end
    end

    // Square wave, high while phase is below the tone value
    always_comb begin
        tone_level.l = (phase.l < ctrl.tone_l) ? level_max : '0;
        tone_level.r = (phase.r < ctrl.tone_r) ? level_max : '0;
    end

endmodule

/* design/audio_regs.sv */
`timescale 1ns/1ps

module audio_regs import audio_mix_pkg::*, audio_reg_pkg::*; (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        gx4000_mode,
    input  logic        cpu_wr,
    input  reg_addr_t   cpu_addr,
    input  sample_t     cpu_data,
    output audio_ctrl_t ctrl
);

    reg_addr_t  sfx_offset;
    logic       sfx_hit;
    voice_idx_t sfx_idx;
    sfx_field_t sfx_field;
    logic       wr_en;

    assign wr_en = gx4000_mode && cpu_wr;

    // Map an offset in the voice window to voice index and field
    always_comb begin
        sfx_offset = cpu_addr - addr_sfx_base;
        sfx_hit = 1'b0;
        sfx_idx = '0;
        sfx_field = '0;
        if (cpu_addr >= addr_sfx_base) begin
            for (int v = 0; v < num_voices; v++) begin
                if (sfx_offset >= reg_addr_t'(v * sfx_stride) &&
                    sfx_offset < reg_addr_t'((v + 1) * sfx_stride)) begin
                    sfx_hit = 1'b1;
                    sfx_idx = voice_idx_t'(v);
                    sfx_field = sfx_field_t'(sfx_offset - reg_addr_t'(v * sfx_stride));
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ctrl <= ctrl_reset;
        end else if (wr_en) begin
            case (cpu_addr)
                addr_volume_l: ctrl.volume_l <= cpu_data;
                addr_volume_r: ctrl.volume_r <= cpu_data;
                addr_tone_l:   ctrl.tone_l <= cpu_data;
                addr_tone_r:   ctrl.tone_r <= cpu_data;
                default: begin
                    // Unknown offsets fall through without effect
                    if (sfx_hit) begin
                        case (sfx_field)
                            sfx_field_volume: ctrl.voice[sfx_idx].volume <= cpu_data;
                            sfx_field_freq:   ctrl.voice[sfx_idx].freq <= cpu_data;
                            sfx_field_pan:    ctrl.voice[sfx_idx].pan <= cpu_data;
                            sfx_field_active: ctrl.voice[sfx_idx].active <= cpu_data[0];
                            default: ;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

/* design/audio_reg_pkg.sv */
package audio_reg_pkg;

    import audio_mix_pkg::*;

    // Register offset from the low CPU address byte
    typedef logic [7:0] reg_addr_t;

    // Basic audio registers
    localparam reg_addr_t addr_volume_l = 8'h40;
    localparam reg_addr_t addr_volume_r = 8'h41;
    localparam reg_addr_t addr_tone_l   = 8'h42;
    localparam reg_addr_t addr_tone_r   = 8'h43;

    // Voice n starts at base + stride * n
    localparam reg_addr_t addr_sfx_base = 8'h46;
    localparam int sfx_stride = 5;

    // Field offsets inside one voice, +2 is reserved
    typedef logic [2:0] sfx_field_t;

    localparam sfx_field_t sfx_field_volume = 3'd0;
    localparam sfx_field_t sfx_field_freq   = 3'd1;
    localparam sfx_field_t sfx_field_pan    = 3'd3;
    localparam sfx_field_t sfx_field_active = 3'd4;

    // Everything the datapath reads from the register map
    typedef struct packed {
        sample_t    volume_l;
        sample_t    volume_r;
        sample_t    tone_l;
        sample_t    tone_r;
        voice_cfg_t [num_voices-1:0] voice;
    } audio_ctrl_t;

    localparam audio_ctrl_t ctrl_reset = '0;

endpackage

/* design/audio_mix_pkg.sv */
package audio_mix_pkg;

    // One audio level on either channel
    typedef logic [7:0] sample_t;

    localparam int num_voices = 4;

    // Wide enough for four full-scale terms without wrap
    localparam int mix_w = 10;

    localparam sample_t level_max = 8'hFF;
    localparam sample_t limit_ceiling = 8'hF0;

    typedef logic [mix_w-1:0] mix_t;
    typedef logic [$clog2(num_voices)-1:0] voice_idx_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // Settings of one sound-effect voice
    typedef struct packed {
        sample_t volume;
        sample_t freq;
        sample_t pan;
        logic    active;
    } voice_cfg_t;

    // Saturate a widened sum at the given ceiling
    function automatic sample_t clip_to(mix_t value, sample_t ceiling);
        if (value > mix_t'(ceiling)) begin
            return ceiling;
        end
        return value[7:0];
    endfunction

endpackage
